//--- src/cache_dir_pkg.sv
package cache_dir_pkg;

    // ------------------------------
    // Address geometry
    // ------------------------------

    // Byte address as seen on the command stream
    localparam int ADDR_W   = 32;
    // Offset inside a 16-byte line
    localparam int OFFSET_W = 4;
    // Line address, split later into tag and set index
    localparam int LINE_W   = ADDR_W - OFFSET_W;

    // ------------------------------
    // Stream and way types
    // ------------------------------

    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FILL  = 2'd2,
        OP_INVAL = 2'd3
    } dir_op_t;

    // One command per lookup, the offset bits of addr are ignored
    typedef struct packed {
        dir_op_t           op;
        logic [ADDR_W-1:0] addr;
    } dir_cmd_t;

    // Way is the hitting way, or the victim way on a fill miss
    // The write-back address is zero unless wb is set
    typedef struct packed {
        logic              hit;
        logic [7:0]        way;
        logic              wb;
        logic [ADDR_W-1:0] wb_addr;
    } dir_rsp_t;

    // Status and tag of one way for the set being looked up
    // The stored tag is zero-extended to the full line address width
    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [LINE_W-1:0] tag;
        logic              match;
    } way_entry_t;

endpackage

//--- src/dir_status_memory.sv
`timescale 1ns/1ps

module dir_status_memory #(
    parameter int INDEX_W = 4
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // Port 0 writes the two arrays independently
    input  logic [INDEX_W-1:0] port0_index_i,
    input  logic               port0_valid_i,
    input  logic               port0_dirty_i,
    input  logic               port0_valid_write_i,
    input  logic               port0_dirty_write_i,
    // Port 1 reads both arrays into output registers
    input  logic [INDEX_W-1:0] port1_index_i,
    input  logic               port1_read_i,
    output logic               port1_valid_o,
    output logic               port1_dirty_o
);

    localparam int SETS = 1 << INDEX_W;

    // Held as flat vectors so that a reset clears every set in one edge
    logic [SETS-1:0] valid_mem;
    logic [SETS-1:0] dirty_mem;

    // ------------------------------
    // Port 0 writes
    // ------------------------------

    // Only the valid bits start at zero, a dirty bit is ignored while its line is invalid
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_mem <= '0;
        end else if (port0_valid_write_i) begin
            valid_mem[port0_index_i] <= port0_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (port0_dirty_write_i) begin
            dirty_mem[port0_index_i] <= port0_dirty_i;
        end
    end

    // ------------------------------
    // Port 1 reads
    // ------------------------------

    // Output registers keep their value while no read is issued
    always_ff @(posedge clk_i) begin
        if (port1_read_i) begin
            port1_valid_o <= valid_mem[port1_index_i];
            port1_dirty_o <= dirty_mem[port1_index_i];
        end
    end

    // A line being invalidated must not come out of the same write marked dirty
    a_no_dirty_on_invalidate : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (port0_valid_write_i && !port0_valid_i) |-> !(port0_dirty_write_i && port0_dirty_i)
    );

endmodule

//--- src/dir_way.sv
`timescale 1ns/1ps

module dir_way #(
    parameter int INDEX_W = 4
) (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    // Lookup side
    input  logic                                     rd_en_i,
    input  logic [INDEX_W-1:0]                       rd_index_i,
    input  logic [cache_dir_pkg::LINE_W-INDEX_W-1:0] rd_tag_i,
    // Update side
    input  logic [INDEX_W-1:0]                       wr_index_i,
    input  logic [cache_dir_pkg::LINE_W-INDEX_W-1:0] wr_tag_i,
    input  logic                                     wr_tag_en_i,
    input  logic                                     wr_valid_en_i,
    input  logic                                     wr_dirty_en_i,
    input  logic                                     wr_valid_i,
    input  logic                                     wr_dirty_i,
    output cache_dir_pkg::way_entry_t                entry_o
);

    import cache_dir_pkg::*;

    localparam int TAG_W = LINE_W - INDEX_W;
    localparam int SETS  = 1 << INDEX_W;

    logic [TAG_W-1:0] tag_mem [SETS];
    logic [TAG_W-1:0] tag_q;
    logic [TAG_W-1:0] lookup_q;
    logic             valid_q;
    logic             dirty_q;

    // ------------------------------
    // Tag array
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (wr_tag_en_i) begin
            tag_mem[wr_index_i] <= wr_tag_i;
        end
    end

    // The lookup tag is kept next to the stored tag so the compare sees one cycle
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            tag_q    <= tag_mem[rd_index_i];
            lookup_q <= rd_tag_i;
        end
    end

    // Status bits are read on the same strobe, so all fields stay aligned
    dir_status_memory #(
        .INDEX_W (INDEX_W)
    ) u_status (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .port0_index_i       (wr_index_i),
        .port0_valid_i       (wr_valid_i),
        .port0_dirty_i       (wr_dirty_i),
        .port0_valid_write_i (wr_valid_en_i),
        .port0_dirty_write_i (wr_dirty_en_i),
        .port1_index_i       (rd_index_i),
        .port1_read_i        (rd_en_i),
        .port1_valid_o       (valid_q),
        .port1_dirty_o       (dirty_q)
    );

    // ------------------------------
    // Compare
    // ------------------------------

    always_comb begin
        entry_o.valid = valid_q;
        entry_o.dirty = dirty_q;
        entry_o.tag   = LINE_W'(tag_q);
        // A stale tag in an invalid set never counts as a hit
        entry_o.match = valid_q && (tag_q == lookup_q);
    end

endmodule

//--- src/dir_request_stage.sv
`timescale 1ns/1ps

module dir_request_stage #(
    parameter int INDEX_W = 4
) (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    // Command stream
    input  logic                                     cmd_valid_i,
    input  cache_dir_pkg::dir_cmd_t                  cmd_i,
    output logic                                     cmd_ready_o,
    // Read strobe shared by every way
    output logic                                     rd_en_o,
    output logic [INDEX_W-1:0]                       rd_index_o,
    output logic [cache_dir_pkg::LINE_W-INDEX_W-1:0] rd_tag_o,
    // Command aligned with the way outputs
    output logic                                     req_valid_o,
    output cache_dir_pkg::dir_cmd_t                  req_cmd_o,
    // Feedback from the resolve stage
    input  logic                                     stall_i,
    input  logic [INDEX_W-1:0]                       busy_index_i,
    input  logic                                     busy_valid_i
);

    import cache_dir_pkg::*;

    localparam int TAG_LSB = OFFSET_W + INDEX_W;

    logic               hold_valid;
    dir_cmd_t           hold_cmd;
    logic [INDEX_W-1:0] cmd_index;
    logic [INDEX_W-1:0] hold_index;
    logic               hazard;
    logic               accept;

    assign cmd_index  = cmd_i.addr[OFFSET_W +: INDEX_W];
    assign hold_index = hold_cmd.addr[OFFSET_W +: INDEX_W];

    // An older command to the same set has not written its ways back yet,
    // so a read issued now would miss that update
    assign hazard = (hold_valid && (hold_index == cmd_index)) ||
                    (busy_valid_i && (busy_index_i == cmd_index));

    assign cmd_ready_o = !stall_i && !hazard;
    assign accept      = cmd_valid_i && cmd_ready_o;

    // The ways keep their outputs while the pipeline is frozen
    assign rd_en_o    = hold_valid && !stall_i;
    assign rd_index_o = hold_index;
    assign rd_tag_o   = hold_cmd.addr[ADDR_W-1:TAG_LSB];

    // ------------------------------
    // Pipeline registers
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hold_valid  <= 1'b0;
            req_valid_o <= 1'b0;
        end else if (!stall_i) begin
            hold_valid  <= accept;
            req_valid_o <= hold_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            if (accept) begin
                hold_cmd <= cmd_i;
            end
            if (hold_valid) begin
                req_cmd_o <= hold_cmd;
            end
        end
    end

    // The index compare depends on cmd_i, so the sender must not change it while waiting
    a_cmd_stable : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (cmd_valid_i && !cmd_ready_o) |=> (cmd_valid_i && $stable(cmd_i))
    );

endmodule

//--- src/dir_resolve_stage.sv
`timescale 1ns/1ps

module dir_resolve_stage #(
    parameter int INDEX_W = 4,
    parameter int WAYS    = 2
) (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    // From the request stage
    input  logic                                     req_valid_i,
    input  cache_dir_pkg::dir_cmd_t                  req_cmd_i,
    // From the ways
    input  cache_dir_pkg::way_entry_t                entries_i [WAYS],
    // Way updates
    output logic [INDEX_W-1:0]                       wr_index_o,
    output logic [cache_dir_pkg::LINE_W-INDEX_W-1:0] wr_tag_o,
    output logic [WAYS-1:0]                          wr_tag_en_o,
    output logic [WAYS-1:0]                          wr_valid_en_o,
    output logic [WAYS-1:0]                          wr_dirty_en_o,
    output logic                                     wr_valid_o,
    output logic                                     wr_dirty_o,
    // Back to the request stage
    output logic                                     stall_o,
    output logic [INDEX_W-1:0]                       busy_index_o,
    output logic                                     busy_valid_o,
    // Response stream
    output logic                                     rsp_valid_o,
    output cache_dir_pkg::dir_rsp_t                  rsp_o,
    input  logic                                     rsp_ready_i
);

    import cache_dir_pkg::*;

    localparam int TAG_W = LINE_W - INDEX_W;
    localparam int SETS  = 1 << INDEX_W;
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;

    logic [INDEX_W-1:0] req_index;
    logic [TAG_W-1:0]   req_tag;
    logic [WAYS-1:0]    match_vec;
    logic               hit;
    logic [WAY_W-1:0]   hit_way;
    logic               any_free;
    logic [WAY_W-1:0]   free_way;
    logic [WAY_W-1:0]   victim;
    way_entry_t         victim_entry;
    logic [WAY_W-1:0]   fill_ptr [SETS];
    logic               ptr_advance;

    dir_rsp_t           rsp_next;
    logic [WAYS-1:0]    tag_en_next;
    logic [WAYS-1:0]    valid_en_next;
    logic [WAYS-1:0]    dirty_en_next;
    logic               valid_next;
    logic               dirty_next;
    logic [WAYS-1:0]    tag_en_q;
    logic [WAYS-1:0]    valid_en_q;
    logic [WAYS-1:0]    dirty_en_q;
    logic               advance;
    logic               rsp_fire;

    assign req_index = req_cmd_i.addr[OFFSET_W +: INDEX_W];
    assign req_tag   = req_cmd_i.addr[ADDR_W-1:OFFSET_W+INDEX_W];

    // The item here is the only one that can still change its set before
    // a younger read, so the request stage checks new commands against it
    assign busy_valid_o = req_valid_i;
    assign busy_index_o = req_index;

    // ------------------------------
    // Way selection
    // ------------------------------

    // Scanning from the top leaves the lowest free way in free_way
    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        any_free = 1'b0;
        free_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            match_vec[w] = entries_i[w].match;
            if (entries_i[w].match) begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
            if (!entries_i[w].valid) begin
                any_free = 1'b1;
                free_way = WAY_W'(w);
            end
        end
    end

    // Round robin only decides when the whole set is occupied
    assign victim       = any_free ? free_way : fill_ptr[req_index];
    assign victim_entry = entries_i[victim];

    // ------------------------------
    // Operation decode
    // ------------------------------

    always_comb begin
        rsp_next      = '0;
        tag_en_next   = '0;
        valid_en_next = '0;
        dirty_en_next = '0;
        valid_next    = 1'b0;
        dirty_next    = 1'b0;
        ptr_advance   = 1'b0;
        rsp_next.hit  = hit;
        if (hit) begin
            rsp_next.way = 8'(hit_way);
        end
        case (req_cmd_i.op)
            OP_WRITE: begin
                if (hit) begin
                    dirty_en_next[hit_way] = 1'b1;
                    dirty_next             = 1'b1;
                end
            end
            OP_FILL: begin
                // A fill hit leaves the set alone
                if (!hit) begin
                    rsp_next.way = 8'(victim);
                    rsp_next.wb  = victim_entry.valid && victim_entry.dirty;
                    if (rsp_next.wb) begin
                        rsp_next.wb_addr = {victim_entry.tag[TAG_W-1:0], req_index,
                                            {OFFSET_W{1'b0}}};
                    end
                    tag_en_next[victim]   = 1'b1;
                    valid_en_next[victim] = 1'b1;
                    dirty_en_next[victim] = 1'b1;
                    valid_next            = 1'b1;
                    ptr_advance           = !any_free;
                end
            end
            OP_INVAL: begin
                // Dirty stays as it was, it means nothing once valid is gone
                if (hit) begin
                    rsp_next.wb = entries_i[hit_way].dirty;
                    if (rsp_next.wb) begin
                        rsp_next.wb_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};
                    end
                    valid_en_next[hit_way] = 1'b1;
                end
            end
            default: begin
                // read lookups only report
            end
        endcase
    end

    // ------------------------------
    // Response register
    // ------------------------------

    assign rsp_fire = rsp_valid_o && rsp_ready_i;
    assign stall_o  = rsp_valid_o && !rsp_ready_i;
    assign advance  = !stall_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else if (advance) begin
            rsp_valid_o <= req_valid_i;
        end
    end

    // The update travels with the response and lands when the response leaves
    always_ff @(posedge clk_i) begin
        if (advance && req_valid_i) begin
            rsp_o      <= rsp_next;
            wr_index_o <= req_index;
            wr_tag_o   <= req_tag;
            tag_en_q   <= tag_en_next;
            valid_en_q <= valid_en_next;
            dirty_en_q <= dirty_en_next;
            wr_valid_o <= valid_next;
            wr_dirty_o <= dirty_next;
        end
    end

    assign wr_tag_en_o   = tag_en_q & {WAYS{rsp_fire}};
    assign wr_valid_en_o = valid_en_q & {WAYS{rsp_fire}};
    assign wr_dirty_en_o = dirty_en_q & {WAYS{rsp_fire}};

    // Fill pointers step once per evicting fill, when the item is taken in
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < SETS; s++) begin
                fill_ptr[s] <= '0;
            end
        end else if (advance && req_valid_i && ptr_advance) begin
            if (fill_ptr[req_index] == WAY_W'(WAYS - 1)) begin
                fill_ptr[req_index] <= '0;
            end else begin
                fill_ptr[req_index] <= fill_ptr[req_index] + 1'b1;
            end
        end
    end

    // Two ways holding one tag would mean an earlier fill ignored a hit
    a_single_match : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i |-> $onehot0(match_vec)
    );

endmodule

//--- src/cache_dir_top.sv
`timescale 1ns/1ps

module cache_dir_top #(
    parameter int INDEX_W = 4,
    parameter int WAYS    = 2
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Command stream
    input  logic                    cmd_valid_i,
    input  cache_dir_pkg::dir_cmd_t cmd_i,
    output logic                    cmd_ready_o,
    // Response stream
    output logic                    rsp_valid_o,
    output cache_dir_pkg::dir_rsp_t rsp_o,
    input  logic                    rsp_ready_i
);

    import cache_dir_pkg::*;

    localparam int TAG_W = LINE_W - INDEX_W;

    // Lookup broadcast to every way
    logic               rd_en;
    logic [INDEX_W-1:0] rd_index;
    logic [TAG_W-1:0]   rd_tag;

    // Request stage to resolve stage
    logic               req_valid;
    dir_cmd_t           req_cmd;
    logic               stall;
    logic [INDEX_W-1:0] busy_index;
    logic               busy_valid;

    // Way results and updates
    way_entry_t         entries [WAYS];
    logic [INDEX_W-1:0] wr_index;
    logic [TAG_W-1:0]   wr_tag;
    logic [WAYS-1:0]    wr_tag_en;
    logic [WAYS-1:0]    wr_valid_en;
    logic [WAYS-1:0]    wr_dirty_en;
    logic               wr_valid;
    logic               wr_dirty;

    dir_request_stage #(
        .INDEX_W (INDEX_W)
    ) u_request (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .cmd_ready_o  (cmd_ready_o),
        .rd_en_o      (rd_en),
        .rd_index_o   (rd_index),
        .rd_tag_o     (rd_tag),
        .req_valid_o  (req_valid),
        .req_cmd_o    (req_cmd),
        .stall_i      (stall),
        .busy_index_i (busy_index),
        .busy_valid_i (busy_valid)
    );

    // One identical block per way, each with its own enable bits
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        dir_way #(
            .INDEX_W (INDEX_W)
        ) u_way (
            .clk_i         (clk_i),
            .rst_n_i       (rst_n_i),
            .rd_en_i       (rd_en),
            .rd_index_i    (rd_index),
            .rd_tag_i      (rd_tag),
            .wr_index_i    (wr_index),
            .wr_tag_i      (wr_tag),
            .wr_tag_en_i   (wr_tag_en[w]),
            .wr_valid_en_i (wr_valid_en[w]),
            .wr_dirty_en_i (wr_dirty_en[w]),
            .wr_valid_i    (wr_valid),
            .wr_dirty_i    (wr_dirty),
            .entry_o       (entries[w])
        );
    end

    dir_resolve_stage #(
        .INDEX_W (INDEX_W),
        .WAYS    (WAYS)
    ) u_resolve (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid),
        .req_cmd_i     (req_cmd),
        .entries_i     (entries),
        .wr_index_o    (wr_index),
        .wr_tag_o      (wr_tag),
        .wr_tag_en_o   (wr_tag_en),
        .wr_valid_en_o (wr_valid_en),
        .wr_dirty_en_o (wr_dirty_en),
        .wr_valid_o    (wr_valid),
        .wr_dirty_o    (wr_dirty),
        .stall_o       (stall),
        .busy_index_o  (busy_index),
        .busy_valid_o  (busy_valid),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_o         (rsp_o),
        .rsp_ready_i   (rsp_ready_i)
    );

endmodule

//--- verification/tb_cache_dir.sv
`timescale 1ns/1ps

module tb_cache_dir;

    import cache_dir_pkg::*;

    localparam int INDEX_W       = 4;
    localparam int WAYS          = 2;
    localparam int TAG_W         = LINE_W - INDEX_W;
    localparam int SETS          = 1 << INDEX_W;
    localparam int DIRECTED_CMDS = 23;
    localparam int RANDOM_CMDS   = 400;
    localparam int LIMIT_CYCLES  = (DIRECTED_CMDS + RANDOM_CMDS) * 20 + 200;

    logic     clk_i;
    logic     rst_n_i;
    logic     cmd_valid_i;
    dir_cmd_t cmd_i;
    logic     cmd_ready_o;
    logic     rsp_valid_o;
    dir_rsp_t rsp_o;
    logic     rsp_ready_i;

    // Reference copy of the directory, updated in issue order
    logic [TAG_W-1:0] ref_tag   [WAYS][SETS];
    logic             ref_valid [WAYS][SETS];
    logic             ref_dirty [WAYS][SETS];
    int               ref_ptr   [SETS];

    dir_rsp_t exp_q [$];
    int       errors;
    int       checks;
    int       tests_run;
    int       tests_failed;
    int       test_errors_at_start;
    int       accepted_count;
    int       rsp_count;
    int       stall_cycles;
    logic     bp_enable;

    cache_dir_top #(
        .INDEX_W (INDEX_W),
        .WAYS    (WAYS)
    ) dut0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .cmd_ready_o (cmd_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ------------------------------
    // Reference model
    // ------------------------------

    // Applies one command to the reference arrays and returns the response it should get
    function automatic dir_rsp_t predict_rsp(input dir_cmd_t cmd);
        dir_rsp_t           rsp;
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        int                 hit_w;
        int                 vic;
        rsp   = '0;
        idx   = cmd.addr[OFFSET_W +: INDEX_W];
        tag   = cmd.addr[ADDR_W-1 -: TAG_W];
        hit_w = -1;
        vic   = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[w][idx] && (ref_tag[w][idx] == tag)) begin
                hit_w = w;
            end
        end
        if (hit_w >= 0) begin
            rsp.hit = 1'b1;
            rsp.way = 8'(hit_w);
        end
        if (cmd.op == OP_WRITE && hit_w >= 0) begin
            ref_dirty[hit_w][idx] = 1'b1;
        end
        if (cmd.op == OP_FILL && hit_w < 0) begin
            // The lowest free way goes first and the pointer only decides in a full set
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!ref_valid[w][idx]) begin
                    vic = w;
                end
            end
            if (vic < 0) begin
                vic          = ref_ptr[idx];
                ref_ptr[idx] = (ref_ptr[idx] + 1) % WAYS;
            end
            rsp.way = 8'(vic);
            if (ref_valid[vic][idx] && ref_dirty[vic][idx]) begin
                rsp.wb      = 1'b1;
                rsp.wb_addr = {ref_tag[vic][idx], idx, {OFFSET_W{1'b0}}};
            end
            ref_tag[vic][idx]   = tag;
            ref_valid[vic][idx] = 1'b1;
            ref_dirty[vic][idx] = 1'b0;
        end
        if (cmd.op == OP_INVAL && hit_w >= 0) begin
            rsp.wb = ref_dirty[hit_w][idx];
            if (rsp.wb) begin
                rsp.wb_addr = {tag, idx, {OFFSET_W{1'b0}}};
            end
            ref_valid[hit_w][idx] = 1'b0;
        end
        return rsp;
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int idx, input int off);
        return {TAG_W'(tag), INDEX_W'(idx), OFFSET_W'(off)};
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    // Called on a falling edge and returns on the falling edge after the transfer
    task automatic issue_cmd(input dir_op_t op, input logic [ADDR_W-1:0] addr);
        dir_cmd_t cmd;
        cmd.op      = op;
        cmd.addr    = addr;
        cmd_valid_i = 1'b1;
        cmd_i       = cmd;
        // Ready settles a moment after the edge, once rsp_ready_i is driven too
        #1;
        while (!cmd_ready_o) begin
            stall_cycles++;
            @(negedge clk_i);
            #1;
        end
        exp_q.push_back(predict_rsp(cmd));
        accepted_count++;
        @(negedge clk_i);
    endtask

    task automatic idle_cycle();
        cmd_valid_i = 1'b0;
        @(negedge clk_i);
    endtask

    task automatic drain_responses();
        cmd_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
    endtask

    task automatic start_test();
        test_errors_at_start = errors;
    endtask

    task automatic end_test(input int num, input string name);
        drain_responses();
        tests_run++;
        if (errors == test_errors_at_start) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", num, name,
                     errors - test_errors_at_start);
        end
    endtask

    // ------------------------------
    // Response side
    // ------------------------------

    // Ready is driven on the falling edge, and a response seen with ready high
    // transfers on the next rising edge
    initial begin : compare_rsp
        dir_rsp_t exp;
        rsp_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            if (bp_enable) begin
                rsp_ready_i = ($urandom % 4) != 0;
            end else begin
                rsp_ready_i = 1'b1;
            end
            if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
                rsp_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Response at %0t arrived with no command outstanding", $time);
                end else begin
                    exp = exp_q.pop_front();
                    check_field("rsp_o.hit", 32'(rsp_o.hit), 32'(exp.hit));
                    check_field("rsp_o.way", 32'(rsp_o.way), 32'(exp.way));
                    check_field("rsp_o.wb", 32'(rsp_o.wb), 32'(exp.wb));
                    check_field("rsp_o.wb_addr", rsp_o.wb_addr, exp.wb_addr);
                end
            end
        end
    end

    initial begin : watchdog
        repeat (LIMIT_CYCLES) @(posedge clk_i);
        $display("Timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin : main
        int idx;
        int tag_sel;
        void'($urandom(32'h8998e453));
        rst_n_i        = 1'b0;
        cmd_valid_i    = 1'b0;
        cmd_i          = '0;
        bp_enable      = 1'b0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        accepted_count = 0;
        rsp_count      = 0;
        stall_cycles   = 0;
        for (int s = 0; s < SETS; s++) begin
            ref_ptr[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                ref_valid[w][s] = 1'b0;
                ref_dirty[w][s] = 1'b0;
                ref_tag[w][s]   = '0;
            end
        end
        // Two rising edges pass with reset low
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        start_test();
        check_field("cmd_ready_o", 32'(cmd_ready_o), 32'd1);
        check_field("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
        tag_sel = int'($urandom % 64);
        issue_cmd(OP_READ, make_addr(tag_sel, 3, 5));
        issue_cmd(OP_FILL, make_addr(tag_sel, 3, 0));
        end_test(1, "reset state misses");

        start_test();
        issue_cmd(OP_FILL, make_addr(17, 7, 0));
        issue_cmd(OP_READ, make_addr(17, 7, 12));
        issue_cmd(OP_READ, make_addr(18, 7, 12));
        end_test(2, "fill then read");

        // Two ways, so every fill after the second evicts by round robin
        start_test();
        issue_cmd(OP_FILL, make_addr(1, 5, 0));
        issue_cmd(OP_WRITE, make_addr(1, 5, 4));
        issue_cmd(OP_FILL, make_addr(2, 5, 0));
        issue_cmd(OP_FILL, make_addr(3, 5, 0));
        issue_cmd(OP_FILL, make_addr(4, 5, 0));
        issue_cmd(OP_WRITE, make_addr(4, 5, 8));
        issue_cmd(OP_FILL, make_addr(5, 5, 0));
        issue_cmd(OP_FILL, make_addr(6, 5, 0));
        end_test(3, "round robin eviction");

        start_test();
        issue_cmd(OP_FILL, make_addr(33, 10, 0));
        issue_cmd(OP_WRITE, make_addr(33, 10, 2));
        issue_cmd(OP_INVAL, make_addr(33, 10, 0));
        issue_cmd(OP_INVAL, make_addr(33, 10, 0));
        end_test(4, "invalidate dirty line");

        // No idle cycles between commands, so the index hazard must stall
        start_test();
        stall_cycles = 0;
        issue_cmd(OP_FILL, make_addr(40, 12, 0));
        issue_cmd(OP_WRITE, make_addr(40, 12, 1));
        issue_cmd(OP_READ, make_addr(40, 12, 2));
        issue_cmd(OP_FILL, make_addr(41, 12, 0));
        issue_cmd(OP_INVAL, make_addr(40, 12, 0));
        issue_cmd(OP_READ, make_addr(40, 12, 3));
        drain_responses();
        if (stall_cycles == 0) begin
            errors++;
            $display("No hazard stall was seen on back-to-back commands to one set");
        end
        end_test(5, "back-to-back same index");

        // Few tags over few sets, so hits, evictions and hazards all happen
        start_test();
        bp_enable = 1'b1;
        for (int n = 0; n < RANDOM_CMDS; n++) begin
            idx = int'($urandom % 4);
            issue_cmd(dir_op_t'(2'($urandom % 4)),
                      make_addr(int'($urandom % 3), idx, int'($urandom % 16)));
            if (($urandom % 5) == 0) begin
                idle_cycle();
            end
        end
        drain_responses();
        bp_enable = 1'b0;
        if (rsp_count != accepted_count) begin
            errors++;
            $display("%0d commands were accepted but %0d responses came back",
                     accepted_count, rsp_count);
        end
        end_test(6, "random mix with back-pressure");

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d", tests_run,
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
src/cache_dir_pkg.sv
src/dir_status_memory.sv
src/dir_way.sv
src/dir_request_stage.sv
src/dir_resolve_stage.sv
src/cache_dir_top.sv
verification/tb_cache_dir.sv

//--- Makefile
# Verilator build and run for the cache directory testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_dir
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_STR  ?= STATUS: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
